// File: Makefile
# Verilator build and run for the token machine testbench

VERILATOR ?= verilator
TOP ?= tb_token_machine
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/command_sequencer.sv
// command FSM: frame collection, verb decode, reply sending and dispenser control
`timescale 1ns/1ps

module command_sequencer import link_pkg::*, dispense_pkg::*; (
	input logic clk50m,
	input logic reset,
	input byte_t rx_data,
	input logic rx_valid,
	input logic tx_busy,
	input logic [2:0] disp_done,
	output byte_t tx_data,
	output logic tx_start,
	output disp_cmd_t [2:0] disp_cmd,
	output cmd_frame_t frame
);

	typedef enum logic [3:0] {
		s_announce,
		s_collect,
		s_decode,
		s_pong,
		s_ack,
		s_echo,
		s_start,
		s_wait_done,
		s_send_done,
		s_tx_wait
	} seq_state_t;

	seq_state_t state;
	seq_state_t ret_state;
	seq_state_t send_ret;
	byte_t send_byte;
	logic [$clog2(frame_bytes)-1:0] byte_idx;
	logic disp_start;

	// same start for all three, count from the low nibble of each argument
	assign disp_cmd[red] = '{start: disp_start, count: frame.arg1[3:0]};
	assign disp_cmd[blue] = '{start: disp_start, count: frame.arg2[3:0]};
	assign disp_cmd[green] = '{start: disp_start, count: frame.arg3[3:0]};

	// byte to send and where to go once it is out
	always_comb begin
		send_byte = reply_error;
		send_ret = s_announce;
		case (state)
			s_announce: begin
				send_byte = reply_init;
				send_ret = s_collect;
			end
			s_pong: begin
				send_byte = reply_pong;
				send_ret = s_collect;
			end
			s_ack: begin
				send_byte = reply_ack;
				send_ret = s_echo;
			end
			s_echo: begin
				send_byte = frame.verb;
				send_ret = s_start;
			end
			s_send_done: begin
				send_byte = reply_done;
				send_ret = s_collect;
			end
			default: begin
				send_byte = reply_error;
				send_ret = s_announce;
			end
		endcase
	end

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state <= s_announce;
			ret_state <= s_collect;
			byte_idx <= '0;
			frame <= '0;
			tx_start <= 1'b0;
			tx_data <= '0;
			disp_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			disp_start <= 1'b0;
			case (state)
				s_collect: begin
					if (rx_valid) begin
						frame[(frame_bytes - 1 - byte_idx) * 8 +: 8] <= rx_data;
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == ($clog2(frame_bytes))'(frame_bytes - 1))
							state <= s_decode;
					end
				end
				s_decode: begin
					case (frame.verb)
						verb_restart: state <= s_announce;
						verb_ping: state <= s_pong;
						verb_go: state <= s_ack;
						// verb_idle and anything unknown
						default: state <= s_collect;
					endcase
				end
				s_start: begin
					disp_start <= 1'b1;
					state <= s_wait_done;
				end
				s_wait_done: begin
					// done is still high while the start pulse is being taken
					if (&disp_done && !disp_start)
						state <= s_send_done;
				end
				s_tx_wait: begin
					if (!tx_busy && !tx_start)
						state <= ret_state;
				end
				default: begin
					// send states, also recovery from an illegal encoding
					if (!tx_busy) begin
						tx_start <= 1'b1;
						tx_data <= send_byte;
						ret_state <= send_ret;
						state <= s_tx_wait;
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/dispense_pkg.sv
// servo positions, PWM frame and hold constants, dispenser command and colour types
package dispense_pkg;

	localparam logic [7:0] servo_out_pos = 8'h00;
	localparam logic [7:0] servo_in_pos = 8'hf8;

	// pulse width in ticks is position plus base
	localparam int pwm_base = 64;
	localparam int pwm_frame = 512;
	localparam int hold_periods = 4;
	localparam int default_servo_tick = 78;

	typedef logic [3:0] token_count_t;

	typedef struct packed {
		logic start;
		token_count_t count;
	} disp_cmd_t;

	typedef enum logic [1:0] {
		red,
		blue,
		green
	} colour_t;

endpackage

// File: hdl/link_pkg.sv
// serial byte type, verb and reply codes, command frame struct, UART defaults
package link_pkg;

	typedef logic [7:0] byte_t;

	// verbs accepted in the first byte of a frame
	localparam byte_t verb_idle = 8'd0;
	localparam byte_t verb_restart = 8'd1;
	localparam byte_t verb_ping = 8'd2;
	localparam byte_t verb_go = 8'd6;

	// reply bytes sent back to the host
	localparam byte_t reply_init = 8'd1;
	localparam byte_t reply_error = 8'd2;
	localparam byte_t reply_done = 8'd3;
	localparam byte_t reply_ack = 8'd4;
	localparam byte_t reply_pong = 8'd5;

	// verb arrives first, so it sits in the top byte
	typedef struct packed {
		byte_t verb;
		byte_t arg1;
		byte_t arg2;
		byte_t arg3;
	} cmd_frame_t;

	// 50 MHz / 115200 baud
	localparam int default_clks_per_bit = 434;
	localparam int frame_bytes = 4;

endpackage

// File: hdl/seven_seg.sv
// hex nibble to active-low seven-segment decoder, gfedcba order
`timescale 1ns/1ps

module seven_seg (
	input logic [3:0] nibble,
	output logic [6:0] segments
);

	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'ha: segments = 7'b0001000;
			// lower case b and d
			4'hb: segments = 7'b0000011;
			4'hc: segments = 7'b1000110;
			4'hd: segments = 7'b0100001;
			4'he: segments = 7'b0000110;
			default: segments = 7'b0001110;
		endcase
	end

endmodule

// File: hdl/token_dispenser.sv
// token dispenser: tick prescaler, PWM frame counter, stroke FSM and token countdown
`timescale 1ns/1ps

module token_dispenser import dispense_pkg::*; #(
	parameter int servo_tick = default_servo_tick
) (
	input logic clk50m,
	input logic reset,
	input disp_cmd_t cmd,
	output logic pwm,
	output logic done
);

	typedef logic [$clog2(servo_tick + 1)-1:0] tick_cnt_t;
	typedef logic [$clog2(pwm_frame)-1:0] frame_cnt_t;
	typedef logic [$clog2(hold_periods)-1:0] hold_cnt_t;
	typedef enum logic [1:0] {
		st_idle,
		st_arm,
		st_out,
		st_in
	} stroke_t;

	stroke_t state;
	tick_cnt_t tick_cnt;
	frame_cnt_t frame_cnt;
	frame_cnt_t width;
	hold_cnt_t hold_cnt;
	token_count_t tokens;
	logic tick;
	logic frame_end;
	logic hold_end;

	assign tick = (tick_cnt == tick_cnt_t'(servo_tick - 1));
	assign frame_end = tick && (frame_cnt == frame_cnt_t'(pwm_frame - 1));
	assign hold_end = frame_end && (hold_cnt == hold_cnt_t'(hold_periods - 1));

	// in position whenever not pushing out, idle included
	assign width = (state == st_out) ? frame_cnt_t'(servo_out_pos + pwm_base)
		: frame_cnt_t'(servo_in_pos + pwm_base);

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			tick_cnt <= '0;
			frame_cnt <= '0;
			pwm <= 1'b0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick)
				frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;
			pwm <= (frame_cnt < width);
		end
	end

	// strokes change only on frame boundaries so every pulse is whole
	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			tokens <= '0;
			hold_cnt <= '0;
			done <= 1'b1;
		end else begin
			if (state == st_out || state == st_in) begin
				if (hold_end)
					hold_cnt <= '0;
				else if (frame_end)
					hold_cnt <= hold_cnt + 1'b1;
			end
			case (state)
				st_idle: begin
					if (cmd.start) begin
						tokens <= cmd.count;
						done <= 1'b0;
						state <= st_arm;
					end
				end
				st_arm: begin
					if (tokens == '0) begin
						done <= 1'b1;
						state <= st_idle;
					end else if (frame_end) begin
						state <= st_out;
					end
				end
				st_out: begin
					if (hold_end)
						state <= st_in;
				end
				default: begin
					if (hold_end) begin
						tokens <= tokens - 1'b1;
						if (tokens == token_count_t'(1)) begin
							done <= 1'b1;
							state <= st_idle;
						end else begin
							state <= st_out;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/token_machine_top.sv
// top level: UART pair, command sequencer, three dispensers, four hex displays
`timescale 1ns/1ps

module token_machine_top import link_pkg::*, dispense_pkg::*; #(
	parameter int clks_per_bit = default_clks_per_bit,
	parameter int servo_tick = default_servo_tick
) (
	input logic clk50m,
	input logic reset,
	input logic serial_raw,
	output logic serial_return,
	output logic [2:0] pwm,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3
);

	byte_t rx_data;
	logic rx_valid;
	byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	disp_cmd_t [2:0] disp_cmd;
	logic [2:0] disp_done;
	cmd_frame_t frame;

	uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
		.clk50m(clk50m),
		.reset(reset),
		.serial_in(serial_raw),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
		.clk50m(clk50m),
		.reset(reset),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.serial_out(serial_return),
		.tx_busy(tx_busy)
	);

	command_sequencer u_command_sequencer (
		.clk50m(clk50m),
		.reset(reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.tx_busy(tx_busy),
		.disp_done(disp_done),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.disp_cmd(disp_cmd),
		.frame(frame)
	);

	// pwm bit 0 red, 1 blue, 2 green
	for (genvar c = 0; c <= int'(green); c++) begin : g_disp
		token_dispenser #(.servo_tick(servo_tick)) u_token_dispenser (
			.clk50m(clk50m),
			.reset(reset),
			.cmd(disp_cmd[c]),
			.pwm(pwm[c]),
			.done(disp_done[c])
		);
	end

	// verb on the left, arg3 on the right
	seven_seg u_seg_verb (.nibble(frame.verb[3:0]), .segments(hex3));
	seven_seg u_seg_arg1 (.nibble(frame.arg1[3:0]), .segments(hex2));
	seven_seg u_seg_arg2 (.nibble(frame.arg2[3:0]), .segments(hex1));
	seven_seg u_seg_arg3 (.nibble(frame.arg3[3:0]), .segments(hex0));

endmodule

// File: hdl/uart_rx.sv
// 8N1 serial receiver with input synchronizer, start-bit check and mid-bit sampling
`timescale 1ns/1ps

module uart_rx import link_pkg::*; #(
	parameter int clks_per_bit = default_clks_per_bit
) (
	input logic clk50m,
	input logic reset,
	input logic serial_in,
	output byte_t rx_data,
	output logic rx_valid
);

	typedef logic [$clog2(clks_per_bit + 1)-1:0] clk_cnt_t;
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data_bits,
		rx_stop
	} rx_state_t;

	rx_state_t state;
	clk_cnt_t clk_cnt;
	logic [2:0] bit_idx;
	logic [1:0] sync;
	logic line_prev;
	logic half_bit;
	logic full_bit;

	assign half_bit = (clk_cnt == clk_cnt_t'(clks_per_bit / 2 - 1));
	assign full_bit = (clk_cnt == clk_cnt_t'(clks_per_bit - 1));

	// line idles high
	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			sync <= 2'b11;
			line_prev <= 1'b1;
		end else begin
			sync <= {sync[0], serial_in};
			line_prev <= sync[1];
		end
	end

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state <= rx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					if (line_prev && !sync[1])
						state <= rx_start;
				end
				rx_start: begin
					if (half_bit) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch, not a real start bit
						state <= sync[1] ? rx_idle : rx_data_bits;
					end
				end
				rx_data_bits: begin
					if (full_bit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
				end
				default: begin
					if (full_bit) begin
						rx_valid <= sync[1];
						state <= rx_idle;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk50m) begin
		if (state == rx_data_bits && full_bit)
			rx_data <= {sync[1], rx_data[7:1]};
	end

endmodule

// File: hdl/uart_tx.sv
// 8N1 serial transmitter with 10-bit shift register and busy level
`timescale 1ns/1ps

module uart_tx import link_pkg::*; #(
	parameter int clks_per_bit = default_clks_per_bit
) (
	input logic clk50m,
	input logic reset,
	input byte_t tx_data,
	input logic tx_start,
	output logic serial_out,
	output logic tx_busy
);

	typedef logic [$clog2(clks_per_bit + 1)-1:0] clk_cnt_t;

	logic [9:0] shift;
	clk_cnt_t clk_cnt;
	logic [3:0] bits_left;

	assign serial_out = shift[0];

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			shift <= '1;
			clk_cnt <= '0;
			bits_left <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// stop, data, start
				shift <= {1'b1, tx_data, 1'b0};
				clk_cnt <= '0;
				bits_left <= 4'd10;
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == clk_cnt_t'(clks_per_bit - 1)) begin
			clk_cnt <= '0;
			shift <= {1'b1, shift[9:1]};
			bits_left <= bits_left - 1'b1;
			// stop bit just finished
			if (bits_left == 4'd1)
				tx_busy <= 1'b0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

// File: sources.f
hdl/link_pkg.sv
hdl/dispense_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/command_sequencer.sv
hdl/token_dispenser.sv
hdl/seven_seg.sv
hdl/token_machine_top.sv
verif/tb_token_machine.sv

// File: verif/tb_token_machine.sv
// testbench for token_machine_top: clock, reset, serial driver and monitor, PWM counters, tests
`timescale 1ns/1ps

module tb_token_machine import link_pkg::*, dispense_pkg::*; ();

	localparam int tb_clks_per_bit = 8;
	localparam int tb_servo_tick = 1;
	localparam int out_width = (int'(servo_out_pos) + pwm_base) * tb_servo_tick;
	localparam int in_width = (int'(servo_in_pos) + pwm_base) * tb_servo_tick;
	localparam int frame_clks = pwm_frame * tb_servo_tick;
	// whole frame out plus two byte times of slack
	localparam int reply_timeout = (frame_bytes + 2) * 10 * tb_clks_per_bit;
	localparam int done_timeout = 16 * 2 * hold_periods * frame_clks + 1000;

	// active-low gfedcba codes for 2, 7, A, F
	localparam logic [6:0] seg_2 = 7'b0100100;
	localparam logic [6:0] seg_7 = 7'b1111000;
	localparam logic [6:0] seg_a = 7'b0001000;
	localparam logic [6:0] seg_f = 7'b0001110;

	logic clk50m;
	logic reset;
	logic serial_raw;
	logic serial_return;
	logic [2:0] pwm;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	int hi_len [3];
	int out_pulses [3];
	int in_pulses [3];
	int error_count;
	int tests_run;
	int tests_failed;
	logic [31:0] lcg_state;

	token_machine_top #(
		.clks_per_bit(tb_clks_per_bit),
		.servo_tick(tb_servo_tick)
	) u_token_machine_top (
		.clk50m(clk50m),
		.reset(reset),
		.serial_raw(serial_raw),
		.serial_return(serial_return),
		.pwm(pwm),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	always #10 clk50m = ~clk50m;

	// classify each finished high pulse by its width
	always @(negedge clk50m) begin
		for (int c = 0; c < 3; c++) begin
			if (pwm[c] === 1'b1) begin
				hi_len[c]++;
			end else begin
				if (hi_len[c] == out_width)
					out_pulses[c]++;
				if (hi_len[c] == in_width)
					in_pulses[c]++;
				hi_len[c] = 0;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cmd_frame_t make_frame(input byte_t v, input byte_t a1, input byte_t a2,
		input byte_t a3);
		cmd_frame_t f;
		f.verb = v;
		f.arg1 = a1;
		f.arg2 = a2;
		f.arg3 = a3;
		return f;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok === 1'b1) else begin
			$display("ERROR at %0t ns: %s", $time, msg);
			error_count++;
		end
	endtask

	task automatic drive_bit(input logic level);
		serial_raw = level;
		repeat (tb_clks_per_bit) @(posedge clk50m);
		#1;
	endtask

	// verb first, each byte lsb first with start and stop bits
	task automatic send_frame(input cmd_frame_t f);
		byte_t bytes [frame_bytes];
		bytes = '{f.verb, f.arg1, f.arg2, f.arg3};
		@(posedge clk50m);
		#1;
		for (int n = 0; n < frame_bytes; n++) begin
			drive_bit(1'b0);
			for (int i = 0; i < 8; i++)
				drive_bit(bytes[n][i]);
			drive_bit(1'b1);
		end
	endtask

	task automatic recv_byte(input int timeout, output byte_t data, output logic got);
		int waited;
		data = '0;
		got = 1'b0;
		waited = 0;
		while (serial_return !== 1'b0 && waited < timeout) begin
			@(negedge clk50m);
			waited++;
		end
		if (serial_return === 1'b0) begin
			// move to the middle of the start bit
			repeat (tb_clks_per_bit / 2) @(negedge clk50m);
			for (int i = 0; i < 8; i++) begin
				repeat (tb_clks_per_bit) @(negedge clk50m);
				data[i] = serial_return;
			end
			repeat (tb_clks_per_bit) @(negedge clk50m);
			check(serial_return === 1'b1, "stop bit on serial_return is low");
			got = 1'b1;
		end
	endtask

	task automatic expect_byte(input byte_t want, input int timeout, input string what);
		byte_t data;
		logic got;
		recv_byte(timeout, data, got);
		if (!got) begin
			$display("No %s byte arrived on serial_return before the timeout", what);
			error_count++;
		end else begin
			check(data == want, $sformatf("%s byte is %02h, expected %02h", what, data, want));
		end
	endtask

	task automatic clear_pulses();
		for (int c = 0; c < 3; c++) begin
			out_pulses[c] = 0;
			in_pulses[c] = 0;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (error_count != errors_before) begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	initial begin
		byte_t data;
		logic got;
		int errors_before;
		int waited;
		byte_t args [3];
		clk50m = 1'b0;
		reset = 1'b0;
		serial_raw = 1'b1;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		lcg_state = 32'h6f951168;
		for (int c = 0; c < 3; c++)
			hi_len[c] = 0;
		clear_pulses();
		repeat (8) @(posedge clk50m);
		#1;
		reset = 1'b1;

		// announce after reset, idle servos sit in
		errors_before = error_count;
		expect_byte(reply_init, reply_timeout, "init");
		waited = 0;
		while ((in_pulses[0] < 2 || in_pulses[1] < 2 || in_pulses[2] < 2)
			&& waited < 4 * frame_clks) begin
			@(posedge clk50m);
			waited++;
		end
		if (waited >= 4 * frame_clks) begin
			$display("Idle in-width pulses did not appear on every pwm channel in time");
			error_count++;
		end
		for (int c = 0; c < 3; c++)
			check(out_pulses[c] == 0, $sformatf("channel %0d gave out pulses while idle", c));
		end_test("reset announce", errors_before);

		errors_before = error_count;
		fork
			send_frame(make_frame(verb_ping, 8'd7, 8'd10, 8'd15));
			expect_byte(reply_pong, reply_timeout, "pong");
		join
		check(hex3 == seg_2, $sformatf("hex3 is %07b, expected %07b", hex3, seg_2));
		check(hex2 == seg_7, $sformatf("hex2 is %07b, expected %07b", hex2, seg_7));
		check(hex1 == seg_a, $sformatf("hex1 is %07b, expected %07b", hex1, seg_a));
		check(hex0 == seg_f, $sformatf("hex0 is %07b, expected %07b", hex0, seg_f));
		end_test("ping and display", errors_before);

		// upper nibble random too, only the low nibble is a count
		errors_before = error_count;
		for (int c = 0; c < 3; c++) begin
			lcg_state = lcg_next(lcg_state);
			args[c] = lcg_state[31:24];
		end
		clear_pulses();
		fork
			send_frame(make_frame(verb_go, args[0], args[1], args[2]));
			expect_byte(reply_ack, reply_timeout, "ack");
		join
		expect_byte(verb_go, reply_timeout, "verb echo");
		expect_byte(reply_done, done_timeout, "done");
		for (int c = 0; c < 3; c++)
			check(out_pulses[c] == int'(args[c][3:0]) * hold_periods,
				$sformatf("channel %0d gave %0d out pulses, expected %0d", c, out_pulses[c],
				int'(args[c][3:0]) * hold_periods));
		end_test("go with random counts", errors_before);

		errors_before = error_count;
		fork
			send_frame(make_frame(verb_idle, 8'd3, 8'd3, 8'd3));
			recv_byte(reply_timeout, data, got);
		join
		check(!got, "idle verb frame produced a reply byte");
		fork
			send_frame(make_frame(8'd9, 8'd1, 8'd2, 8'd3));
			recv_byte(reply_timeout, data, got);
		join
		check(!got, "unknown verb frame produced a reply byte");
		fork
			send_frame(make_frame(verb_ping, 8'd0, 8'd0, 8'd0));
			expect_byte(reply_pong, reply_timeout, "pong");
		join
		end_test("silent verbs", errors_before);

		errors_before = error_count;
		fork
			send_frame(make_frame(verb_restart, 8'd0, 8'd0, 8'd0));
			expect_byte(reply_init, reply_timeout, "init");
		join
		fork
			send_frame(make_frame(verb_ping, 8'd0, 8'd0, 8'd0));
			expect_byte(reply_pong, reply_timeout, "pong");
		join
		end_test("restart", errors_before);

		errors_before = error_count;
		clear_pulses();
		fork
			send_frame(make_frame(verb_go, 8'd0, 8'd0, 8'd0));
			expect_byte(reply_ack, reply_timeout, "ack");
		join
		expect_byte(verb_go, reply_timeout, "verb echo");
		expect_byte(reply_done, reply_timeout, "done");
		for (int c = 0; c < 3; c++)
			check(out_pulses[c] == 0, $sformatf("channel %0d gave out pulses for count 0", c));
		end_test("go with zero counts", errors_before);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
